/* hdl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// one word size covers data, addresses and instructions
`define CPU_DATA_WIDTH 16

// sixteen registers and r0 always reads as zero
`define CPU_NUM_REGS 16
`define CPU_REG_ADDR_WIDTH 4

`define CPU_OPCODE_WIDTH 4

// both memories hold words and drop address bit 0
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

`endif

/* hdl/cpuPkg.sv */
`default_nettype none
`include "cpu_config.svh"

package cpuPkg;

  typedef logic [`CPU_DATA_WIDTH-1:0] wordT;
  typedef logic [`CPU_REG_ADDR_WIDTH-1:0] regAddrT;

  // listed in encoding order, 0 through 15
  typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
    OpAdd, OpSub, OpXor, OpRed, OpSll, OpSra, OpRor, OpPaddsb,
    OpLw, OpSw, OpLlb, OpLhb, OpB, OpBr, OpPcs, OpHlt
  } opcodeT;

  // condition field of B and BR
  typedef enum logic [2:0] {
    CondNe,  // Z clear
    CondEq,  // Z set
    CondGt,  // Z and N clear
    CondLt,  // N set
    CondGe,  // Z set or N clear
    CondLe,  // Z set or N set
    CondOv,  // V set
    CondUn   // always taken
  } condT;

  typedef enum logic [2:0] {
    AluAdd, AluSub, AluXor, AluSll, AluSra, AluRor
  } aluOpT;

endpackage

`default_nettype wire

/* hdl/fetchStage.sv */
`default_nettype none
`timescale 1ns/1ns
`include "cpu_config.svh"

module fetchStage (
  input  logic         clk,
  input  logic         rst,
  input  logic         imemWrEn,
  input  cpuPkg::wordT imemAddr,
  input  cpuPkg::wordT imemData,
  input  logic         stall,
  input  logic         branchTaken,
  input  cpuPkg::wordT branchTarget,
  output cpuPkg::wordT pc,
  output cpuPkg::wordT ifInst,
  output cpuPkg::wordT ifPcInc
);
  import cpuPkg::*;

  localparam int indexBits = $clog2(`CPU_IMEM_WORDS);

  wordT imem [`CPU_IMEM_WORDS];
  wordT inst;
  wordT pcInc;
  wordT pcNext;
  logic fetchHalt;

  always_ff @(posedge clk) begin
    if (imemWrEn) imem[imemAddr[indexBits:1]] <= imemData;  // program load
  end

  assign inst      = imem[pc[indexBits:1]];
  assign pcInc     = pc + wordT'(2);
  assign fetchHalt = (opcodeT'(inst[15:12]) == OpHlt);

  // a redirect from decode wins over the halt hold
  always_comb begin
    if (branchTaken) pcNext = branchTarget;
    else if (fetchHalt) pcNext = pc;
    else pcNext = pcInc;
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= '0;
    else if (!stall) pc <= pcNext;
  end

  always_ff @(posedge clk) begin
    if (rst || branchTaken) begin
      ifInst  <= '0;  // the wrong-path word becomes a bubble
      ifPcInc <= '0;
    end else if (!stall) begin
      ifInst  <= inst;
      ifPcInc <= pcInc;
    end
  end

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`default_nettype none
`timescale 1ns/1ns

module decodeStage (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::wordT    ifInst, ifPcInc,
  input  cpuPkg::wordT    rdData1, rdData2,
  input  logic            flagZ, flagV, flagN,
  input  cpuPkg::regAddrT exDst,
  input  logic            exWrite, exIsLoad, exSetsFlags,
  input  cpuPkg::regAddrT memDst,
  input  logic            memWrite,
  output cpuPkg::regAddrT rdAddr1, rdAddr2,
  output logic            stall, branchTaken,
  output cpuPkg::wordT    branchTarget,
  output cpuPkg::wordT    idInst, idPcInc, idSrc1, idSrc2,
  output cpuPkg::regAddrT idSrc2Reg,
  output logic            idWrite, idMemRead, idMemWrite,
  output cpuPkg::aluOpT   idAluOp,
  output logic            idSetsZ, idSetsVN, idUseImm, idAddrCalc
);
  import cpuPkg::*;

  opcodeT op;
  aluOpT  aluOp;
  logic   isBubble, isBranch, condMet;
  logic   readsSrc1, readsSrc2;
  logic   loadUse, brHazard, flagHazard;

  assign op       = opcodeT'(ifInst[15:12]);
  assign isBubble = (ifInst == '0);  // the all-zero word never touches the flags
  assign isBranch = op inside {OpB, OpBr};

  // SW, LLB and LHB read their destination field on the second port
  assign rdAddr1 = ifInst[7:4];
  assign rdAddr2 = (op inside {OpSw, OpLlb, OpLhb}) ? ifInst[11:8] : ifInst[3:0];

  assign readsSrc1 = op inside {OpAdd, OpSub, OpXor, OpSll, OpSra, OpRor, OpLw, OpSw, OpBr};
  assign readsSrc2 = op inside {OpAdd, OpSub, OpXor, OpLlb, OpLhb};  // store data uses the bypass

  always_comb begin
    case (op)
      OpSub:   aluOp = AluSub;
      OpXor:   aluOp = AluXor;
      OpSll:   aluOp = AluSll;
      OpSra:   aluOp = AluSra;
      OpRor:   aluOp = AluRor;
      default: aluOp = AluAdd;  // also forms the LW/SW address
    endcase
  end

  always_comb begin
    case (condT'(ifInst[11:9]))
      CondNe:  condMet = !flagZ;
      CondEq:  condMet = flagZ;
      CondGt:  condMet = !flagZ && !flagN;
      CondLt:  condMet = flagN;
      CondGe:  condMet = flagZ || !flagN;
      CondLe:  condMet = flagZ || flagN;
      CondOv:  condMet = flagV;
      default: condMet = 1'b1;
    endcase
  end

  assign loadUse = exIsLoad && ((readsSrc1 && exDst == rdAddr1) ||
                                (readsSrc2 && exDst == rdAddr2));
  // BR uses its register in decode, so writers in execute and memory must drain first
  assign brHazard = (op == OpBr) && (rdAddr1 != '0) &&
                    ((exWrite && exDst == rdAddr1) || (memWrite && memDst == rdAddr1));
  assign flagHazard = isBranch && (condT'(ifInst[11:9]) != CondUn) && exSetsFlags;
  assign stall       = loadUse || brHazard || flagHazard;
  assign branchTaken = isBranch && condMet && !stall;
  assign branchTarget = (op == OpBr) ? rdData1 :
                        ifPcInc + {{6{ifInst[8]}}, ifInst[8:0], 1'b0};

  // HLT rides down the pipe as a load that is also a store
  always_ff @(posedge clk) begin
    if (rst || stall) begin
      idInst     <= '0;
      idWrite    <= 1'b0;
      idMemRead  <= 1'b0;
      idMemWrite <= 1'b0;
      idAluOp    <= AluAdd;
      idSetsZ    <= 1'b0;
      idSetsVN   <= 1'b0;
      idUseImm   <= 1'b0;
      idAddrCalc <= 1'b0;
    end else begin
      idInst     <= ifInst;
      idWrite    <= op inside {OpAdd, OpSub, OpXor, OpSll, OpSra, OpRor,
                               OpLw, OpLlb, OpLhb, OpPcs};
      idMemRead  <= op inside {OpLw, OpHlt};
      idMemWrite <= op inside {OpSw, OpHlt};
      idAluOp    <= aluOp;
      idSetsZ    <= !isBubble && (op inside {OpAdd, OpSub, OpXor, OpSll, OpSra, OpRor});
      idSetsVN   <= !isBubble && (op inside {OpAdd, OpSub});
      idUseImm   <= op inside {OpSll, OpSra, OpRor};
      idAddrCalc <= op inside {OpLw, OpSw};
    end
  end

  always_ff @(posedge clk) begin
    idPcInc   <= ifPcInc;
    idSrc1    <= rdData1;
    idSrc2    <= rdData2;
    idSrc2Reg <= rdAddr2;
  end

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`default_nettype none
`timescale 1ns/1ns
`include "cpu_config.svh"

module registerFile (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::regAddrT rdAddr1, rdAddr2, wrAddr,
  input  logic            wrEn,
  input  cpuPkg::wordT    wrData,
  output cpuPkg::wordT    rdData1, rdData2
);
  import cpuPkg::*;

  wordT regs [`CPU_NUM_REGS];

  // the writeback value shows up on a read of the same register this cycle
  function automatic wordT readPort(regAddrT addr);
    if (addr == '0) return '0;
    if (wrEn && addr == wrAddr) return wrData;
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) regs[i] <= '0;
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  always_comb begin
    rdData1 = readPort(rdAddr1);
    rdData2 = readPort(rdAddr2);
  end

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`default_nettype none
`timescale 1ns/1ns

module executeStage (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::wordT    idInst, idPcInc, idSrc1, idSrc2,
  input  cpuPkg::regAddrT idSrc2Reg,
  input  logic            idWrite, idMemRead, idMemWrite,
  input  cpuPkg::aluOpT   idAluOp,
  input  logic            idSetsZ, idSetsVN, idUseImm, idAddrCalc,
  input  logic            wbEn,
  input  cpuPkg::regAddrT wbReg,
  input  cpuPkg::wordT    wbData,
  output logic            flagZ, flagV, flagN,
  output cpuPkg::regAddrT exDst,
  output logic            exWrite, exIsLoad, exSetsFlags,
  output cpuPkg::wordT    memResult, memStoreData,
  output cpuPkg::regAddrT memDst,
  output logic            memWrite, memLoad, memStore
);
  import cpuPkg::*;

  opcodeT  op;
  regAddrT src1Reg;
  logic    fwdMemA, fwdMemB, fwdWbA, fwdWbB;
  wordT    opA, opB, aluA, aluB, aluOut, result;
  logic [2*$bits(wordT)-1:0] rotWide;
  logic    aluV;

  assign op          = opcodeT'(idInst[15:12]);
  assign src1Reg     = idInst[7:4];
  assign exDst       = idInst[11:8];
  assign exWrite     = idWrite;
  assign exIsLoad    = idMemRead && !idMemWrite;
  assign exSetsFlags = idSetsZ;

  // a load in memory holds only its address, so it is never a forwarding source
  assign fwdMemA = memWrite && !memLoad && memDst != '0 && memDst == src1Reg;
  assign fwdMemB = memWrite && !memLoad && memDst != '0 && memDst == idSrc2Reg;
  assign fwdWbA  = wbEn && wbReg == src1Reg;  // wbEn is never set for r0
  assign fwdWbB  = wbEn && wbReg == idSrc2Reg;
  assign opA = fwdMemA ? memResult : (fwdWbA ? wbData : idSrc1);
  assign opB = fwdMemB ? memResult : (fwdWbB ? wbData : idSrc2);

  assign aluA = idAddrCalc ? {opA[15:1], 1'b0} : opA;
  assign aluB = idAddrCalc ? {{11{idInst[3]}}, idInst[3:0], 1'b0} :
                idUseImm   ? {12'h000, idInst[3:0]} : opB;
  assign rotWide = {aluA, aluA} >> aluB[3:0];

  always_comb begin
    aluV = 1'b0;
    case (idAluOp)
      AluAdd: begin
        aluOut = aluA + aluB;
        aluV   = (aluA[15] == aluB[15]) && (aluOut[15] != aluA[15]);
      end
      AluSub: begin
        aluOut = aluA - aluB;
        aluV   = (aluA[15] != aluB[15]) && (aluOut[15] != aluA[15]);
      end
      AluXor:  aluOut = aluA ^ aluB;
      AluSll:  aluOut = aluA << aluB[3:0];
      AluSra:  aluOut = $signed(aluA) >>> aluB[3:0];
      AluRor:  aluOut = rotWide[15:0];
      default: aluOut = '0;
    endcase
  end

  // LLB and LHB keep the other byte of the destination, read on the second port
  always_comb begin
    case (op)
      OpLlb:   result = {opB[15:8], idInst[7:0]};
      OpLhb:   result = {idInst[7:0], opB[7:0]};
      OpPcs:   result = idPcInc;
      default: result = aluOut;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flagZ <= 1'b0;
      flagV <= 1'b0;
      flagN <= 1'b0;
    end else begin
      if (idSetsZ) flagZ <= (aluOut == '0);
      if (idSetsVN) begin
        flagV <= aluV;
        flagN <= aluOut[15];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memWrite <= 1'b0;
      memLoad  <= 1'b0;
      memStore <= 1'b0;
    end else begin
      memWrite <= idWrite;
      memLoad  <= idMemRead;
      memStore <= idMemWrite;
    end
    memResult    <= result;
    memStoreData <= opB;
    memDst       <= idInst[11:8];
  end

endmodule

`default_nettype wire

/* hdl/memoryStage.sv */
`default_nettype none
`timescale 1ns/1ns
`include "cpu_config.svh"

module memoryStage (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::wordT    memResult, memStoreData,
  input  cpuPkg::regAddrT memDst,
  input  logic            memWrite, memLoad, memStore,
  output logic            wbEn,
  output cpuPkg::regAddrT wbReg,
  output cpuPkg::wordT    wbData,
  output logic            wbHalt
);
  import cpuPkg::*;

  localparam int indexBits = $clog2(`CPU_DMEM_WORDS);

  wordT dmem [`CPU_DMEM_WORDS];
  wordT storeData, loadData, wbResult, wbLoadData;
  logic isHalt, storeBypass, wbIsLoad;

  assign isHalt = memLoad && memStore;  // only HLT sets both
  // a store right behind a load of its data register picks up the loaded word
  assign storeBypass = wbEn && wbIsLoad && (wbReg == memDst);
  assign storeData   = storeBypass ? wbData : memStoreData;
  assign loadData    = dmem[memResult[indexBits:1]];

  always_ff @(posedge clk) begin
    if (memStore && !memLoad) dmem[memResult[indexBits:1]] <= storeData;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wbEn     <= 1'b0;
      wbIsLoad <= 1'b0;
      wbHalt   <= 1'b0;
    end else begin
      wbEn     <= memWrite && (memDst != '0);  // r0 writes stay out of the trace
      wbIsLoad <= memLoad && !memStore;
      if (isHalt) wbHalt <= 1'b1;  // stays set once HLT reaches writeback
    end
  end

  always_ff @(posedge clk) begin
    wbReg      <= memDst;
    wbResult   <= memResult;
    wbLoadData <= loadData;
  end

  assign wbData = wbIsLoad ? wbLoadData : wbResult;

endmodule

`default_nettype wire

/* hdl/cpuTop.sv */
`default_nettype none
`timescale 1ns/1ns

module cpuTop (
  input  logic            clk,
  input  logic            rst,
  input  logic            imemWrEn,
  input  cpuPkg::wordT    imemAddr,
  input  cpuPkg::wordT    imemData,
  output cpuPkg::wordT    pc,
  output logic            hlt,
  output logic            wbEn,
  output cpuPkg::regAddrT wbReg,
  output cpuPkg::wordT    wbData
);
  import cpuPkg::*;

  // fetch to decode and the decode feedback to fetch
  wordT    ifInst, ifPcInc, branchTarget;
  logic    stall, branchTaken;

  // register file read ports
  regAddrT rdAddr1, rdAddr2;
  wordT    rdData1, rdData2;

  // ID/EX
  wordT    idInst, idPcInc, idSrc1, idSrc2;
  regAddrT idSrc2Reg;
  logic    idWrite, idMemRead, idMemWrite;
  aluOpT   idAluOp;
  logic    idSetsZ, idSetsVN, idUseImm, idAddrCalc;

  // flags and the hazard view of execute
  logic    flagZ, flagV, flagN;
  regAddrT exDst;
  logic    exWrite, exIsLoad, exSetsFlags;

  // EX/MEM
  wordT    memResult, memStoreData;
  regAddrT memDst;
  logic    memWrite, memLoad, memStore;

  fetchStage fetch (.*);

  decodeStage decode (.*);

  registerFile regFile (
    .wrAddr (wbReg),
    .wrEn   (wbEn),
    .wrData (wbData),
    .*
  );

  executeStage execute (.*);

  memoryStage memory (
    .wbHalt (hlt),
    .*
  );

endmodule

`default_nettype wire

/* tb/cpuPrograms.svh */
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

// every program starts at address 0 and ends with HLT
localparam int numTests = 5;

string testName [numTests] = '{
  "alu forwarding", "store and load", "constants and pcs", "branches", "halt"
};

// offsets into progWords and traceWords, and the pc that HLT freezes
int   progStart  [numTests] = '{0, 11, 23, 32, 49};
int   progLen    [numTests] = '{11, 12, 9, 17, 5};
int   traceStart [numTests] = '{0, 10, 18, 26, 32};
int   traceLen   [numTests] = '{10, 8, 8, 6, 2};
wordT haltPc     [numTests] = '{16'h0014, 16'h0016, 16'h0010, 16'h0020, 16'h0004};

wordT progWords [54] = '{
  16'hA134, 16'hB112, 16'hA20F, 16'h0312, 16'h1431, 16'h2543,  // llb, lhb, add, sub, xor
  16'h4654, 16'h6768, 16'h5874, 16'h0988, 16'hF000,            // sll 4, ror 8, sra 4, add
  16'hA140, 16'hA2CD, 16'hB2AB, 16'h9212, 16'h8312, 16'h0431,  // sw then lw then a use
  16'h8512, 16'h9513, 16'h8613, 16'h941F, 16'h871F, 16'hF000,  // store right behind a load
  16'hA1FF, 16'hB180, 16'hB27E, 16'hA201, 16'hE300, 16'h0432,  // pcs at 0x8 and 0xe
  16'hA100, 16'hE500, 16'hF000,
  16'hA105, 16'h1211, 16'hC202, 16'hA311, 16'hA422, 16'hC001,  // b eq taken, b ne falls
  16'hA533, 16'h0611, 16'hC401, 16'hA744, 16'hA81E, 16'hDE80,  // b gt taken, br r8
  16'hA955, 16'hF000, 16'hAA66, 16'hAB77, 16'hF000,            // br lands on 0x1e
  16'hA101, 16'h0211, 16'hF000, 16'hA399, 16'h0411             // nothing after hlt commits
};

// {register, value} in writeback order, worked out by hand from 16-bit arithmetic
logic [19:0] traceWords [34] = '{
  20'h1_0034, 20'h1_1234, 20'h2_000F, 20'h3_1243, 20'h4_000F,  // 0x1243 - 0x1234
  20'h5_124C, 20'h6_24C0, 20'h7_C024, 20'h8_FC02, 20'h9_F804,  // sign fills on sra
  20'h1_0040, 20'h2_00CD, 20'h2_ABCD, 20'h3_ABCD, 20'h4_AC0D,  // store at 0x44
  20'h5_ABCD, 20'h6_ABCD, 20'h7_AC0D,                          // 0x46 and 0x3e
  20'h1_00FF, 20'h1_80FF, 20'h2_7E00, 20'h2_7E01, 20'h3_000A,
  20'h4_7E0B, 20'h1_8000, 20'h5_0010,                          // llb keeps the high byte
  20'h1_0005, 20'h2_0000, 20'h5_0033, 20'h6_000A, 20'h8_001E,
  20'hB_0077,
  20'h1_0001, 20'h2_0002
};

`endif

/* tb/cpuTb.sv */
`default_nettype none
`timescale 1ns/1ns

module cpuTb;
  import cpuPkg::*;

  `include "cpuPrograms.svh"

  logic    clk = 1'b0;
  logic    rst;
  logic    imemWrEn;
  wordT    imemAddr, imemData;
  wordT    pc;
  logic    hlt;
  logic    wbEn;
  regAddrT wbReg;
  wordT    wbData;

  int errorCount = 0;
  int passCount = 0;
  int cycleCount = 0;
  int cycleLimit = 1000;

  cpuTop dut (
    .clk      (clk),
    .rst      (rst),
    .imemWrEn (imemWrEn),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .pc       (pc),
    .hlt      (hlt),
    .wbEn     (wbEn),
    .wbReg    (wbReg),
    .wbData   (wbData)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic checkValue(string name, wordT got, wordT want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
      errorCount++;
    end
  endtask

  // the program is written one word per cycle while the core sits in reset
  task automatic loadProgram(int t);
    int i;
    @(posedge clk);
    rst <= 1'b1;
    for (i = 0; i < progLen[t]; i++) begin
      imemWrEn <= 1'b1;
      imemAddr <= wordT'(2 * i);
      imemData <= progWords[progStart[t] + i];
      @(posedge clk);
    end
    imemWrEn <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic runTest(int t);
    int seen;
    int haltCycles;
    int errorsBefore;
    logic [19:0] want;
    seen = 0;
    haltCycles = 0;
    errorsBefore = errorCount;
    loadProgram(t);
    // outputs settle after the rising edge, so look at them half a cycle later
    while (haltCycles < 5) begin
      @(negedge clk);
      if (wbEn) begin
        if (seen < traceLen[t]) begin
          want = traceWords[traceStart[t] + seen];
          checkValue("wbReg", {12'h000, wbReg}, {12'h000, want[19:16]});
          checkValue("wbData", wbData, want[15:0]);
        end
        seen++;
      end
      if (hlt || haltCycles > 0) begin
        checkValue("hlt", {15'h0000, hlt}, 16'h0001);  // hlt stays latched once raised
        checkValue("pc", pc, haltPc[t]);  // pc must hold on the HLT address
        haltCycles++;
      end
    end
    if (seen != traceLen[t]) begin
      $display("test %0d saw %0d register writes where %0d were expected",
               t, seen, traceLen[t]);
      errorCount++;
    end
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("test %0d (%s): passed", t, testName[t]);
    end else begin
      $display("test %0d (%s): failed with %0d errors", t, testName[t],
               errorCount - errorsBefore);
    end
  endtask

  initial begin
    int t;
    rst      = 1'b1;
    imemWrEn = 1'b0;
    imemAddr = '0;
    imemData = '0;
    cycleLimit = 20 * numTests;
    for (t = 0; t < numTests; t++) cycleLimit += 8 * progLen[t];
    for (t = 0; t < numTests; t++) runTest(t);
    $display("%0d tests, %0d passed, %0d failed, %0d errors", numTests, passCount,
             numTests - passCount, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
+incdir+tb
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/registerFile.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
tb/cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpuPkg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/registerFile.sv
      - hdl/executeStage.sv
      - hdl/memoryStage.sv
      - hdl/cpuTop.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/cpuTb.sv
